//--- logic/gain_regs.svh
`ifndef GAIN_REGS_SVH
`define GAIN_REGS_SVH

// Word offsets within the block's register space
localparam int REG_GAIN_COEFF = 0;

`endif

//--- logic/gain_pkg.sv
package gain_pkg;

  // ------------------------------
  // Data path types
  // ------------------------------
  // Sample time, counts items
  typedef logic [63:0] timestamp_t;

  // Complex item, real part in upper half, imaginary part in lower half
  typedef logic [31:0] sample_t;

  // Complex coefficient, same ordering, each part Q1.14
  typedef logic [31:0] coeff_t;

  // One real or imaginary part
  typedef logic signed [15:0] part_t;

  // ------------------------------
  // Fixed-point constants
  // ------------------------------
  localparam int COEFF_FRAC_BITS = 14;

  // 1.0 + 0.0j
  localparam coeff_t COEFF_UNITY = {16'sh4000, 16'sh0000};

  // Saturation limits of one output part
  localparam part_t PART_MAX = 16'sh7fff;
  localparam part_t PART_MIN = 16'sh8000;

  // Queued coefficient command
  typedef struct packed {
    coeff_t     coeff;
    logic       timed;
    timestamp_t ts;
  } gain_cmd_t;

endpackage

//--- logic/ctrl_port_pkg.sv
package ctrl_port_pkg;

  // ------------------------------
  // Control port field widths
  // ------------------------------
  typedef logic [19:0] ctrl_addr_t;
  typedef logic [31:0] ctrl_data_t;

  // Response status codes
  typedef enum logic [1:0] {
    CTRL_STS_OKAY    = 2'd0,
    CTRL_STS_CMD_ERR = 2'd1,
    CTRL_STS_TSF_ERR = 2'd2,
    CTRL_STS_WARNING = 2'd3
  } ctrl_status_e;

  // Single cycle request, optionally carrying an execution time
  typedef struct packed {
    logic                 wr;
    logic                 rd;
    ctrl_addr_t           addr;
    ctrl_data_t           data;
    logic                 has_time;
    gain_pkg::timestamp_t req_time;
  } ctrl_req_t;

  // Response, valid while ack is high
  typedef struct packed {
    logic         ack;
    ctrl_status_e status;
    ctrl_data_t   data;
  } ctrl_resp_t;

endpackage

//--- logic/gain_ctrl_regs.sv
`timescale 1ns/1ps

module gain_ctrl_regs
  import ctrl_port_pkg::*;
  import gain_pkg::*;
#(
  parameter int BASE_ADDR = 0
) (
  input  logic       clk,
  input  logic       rst,
  input  ctrl_req_t  ctrl_req,
  output ctrl_resp_t ctrl_resp,
  input  coeff_t     active_coeff,
  output logic       push,
  output gain_cmd_t  push_cmd,
  input  logic       full
);
  `include "gain_regs.svh"

  // Byte address of the coefficient register, registers are 32-bit words
  localparam ctrl_addr_t COEFF_ADDR = ctrl_addr_t'(BASE_ADDR + 4 * REG_GAIN_COEFF);

  logic coeff_hit;
  logic push_done;

  // Other addresses are ignored entirely
  assign coeff_hit = (ctrl_req.addr == COEFF_ADDR);
  // Queue accepts the pending command this cycle
  assign push_done = push && !full;

  // ------------------------------
  // Pending command payload
  // ------------------------------
  always_ff @(posedge clk) begin
    if (ctrl_req.wr && coeff_hit) begin
      push_cmd.coeff <= ctrl_req.data;
      push_cmd.timed <= ctrl_req.has_time;
      // Untimed commands apply at the next strobe regardless of time
      push_cmd.ts    <= ctrl_req.has_time ? ctrl_req.req_time : '0;
    end
  end

  // ------------------------------
  // Push strobe and responses
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      push      <= 1'b0;
      ctrl_resp <= '0;
    end else begin
      // Responses last a single cycle
      ctrl_resp <= '0;

      // Write ack follows acceptance by the queue
      if (push_done) begin
        push             <= 1'b0;
        ctrl_resp.ack    <= 1'b1;
        ctrl_resp.status <= CTRL_STS_OKAY;
      end

      // Command held until the queue has room
      if (ctrl_req.wr && coeff_hit) begin
        push <= 1'b1;
      end

      // Reads answer one cycle after the request
      if (ctrl_req.rd && coeff_hit) begin
        ctrl_resp.ack <= 1'b1;
        if (ctrl_req.has_time) begin
          // Timed reads are not supported
          ctrl_resp.status <= CTRL_STS_CMD_ERR;
          ctrl_resp.data   <= '0;
        end else begin
          ctrl_resp.status <= CTRL_STS_OKAY;
          ctrl_resp.data   <= active_coeff;
        end
      end
    end
  end

endmodule

//--- logic/coeff_queue.sv
`timescale 1ns/1ps

module coeff_queue
  import gain_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      push,
  input  gain_cmd_t push_cmd,
  output logic      full,
  input  logic      pop,
  output gain_cmd_t head_cmd,
  output logic      not_empty
);
  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  gain_cmd_t        mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Wrap at the last entry, depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full      = (count == CNT_W'(QUEUE_DEPTH));
  assign not_empty = (count != '0);
  // Push on full and pop on empty have no effect
  assign do_push   = push && !full;
  assign do_pop    = pop && not_empty;
  // Head is visible without a read strobe
  assign head_cmd  = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_cmd;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- logic/gain_scheduler.sv
`timescale 1ns/1ps

module gain_scheduler
  import gain_pkg::*;
#(
  parameter int NIPC = 2
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                data_in_stb,
  input  sample_t [NIPC-1:0]  data_in,
  input  timestamp_t          timestamp,
  input  gain_cmd_t           head_cmd,
  input  logic                not_empty,
  output logic                pop,
  output coeff_t              active_coeff,
  output coeff_t  [NIPC-1:0]  item_coeff,
  output sample_t [NIPC-1:0]  item_data,
  output logic                item_stb
);
  // Time of the last item in the current strobe, relative to its first
  localparam timestamp_t LAST_OFFSET = timestamp_t'(NIPC - 1);

  if (NIPC < 1 || NIPC > 8 || (NIPC & (NIPC - 1)) != 0) begin : gen_nipc_check
    $error("NIPC must be a power of two from 1 to 8");
  end

  logic            head_due;
  logic [NIPC-1:0] use_new;

  // ------------------------------
  // Due test on the queue head
  // ------------------------------
  // Untimed heads are always due
  // Timed heads are due once their time falls within this strobe or earlier
  assign head_due = !head_cmd.timed || (head_cmd.ts <= timestamp + LAST_OFFSET);

  // At most one entry per strobe
  assign pop = data_in_stb && not_empty && head_due;

  // Item alignment inside the strobe
  always_comb begin
    for (int i = 0; i < NIPC; i++) begin
      // Items before the head time keep the old coefficient
      use_new[i] = pop && (!head_cmd.timed ||
                           (timestamp + timestamp_t'(i) >= head_cmd.ts));
    end
  end

  // ------------------------------
  // Active coefficient
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      active_coeff <= COEFF_UNITY;
      item_stb     <= 1'b0;
    end else begin
      item_stb <= data_in_stb;
      if (pop) begin
        active_coeff <= head_cmd.coeff;
      end
    end
  end

  // ------------------------------
  // Coefficient and data alignment
  // ------------------------------
  // One register stage, items and coefficients travel together
  always_ff @(posedge clk) begin
    if (data_in_stb) begin
      item_data <= data_in;
      for (int i = 0; i < NIPC; i++) begin
        item_coeff[i] <= use_new[i] ? head_cmd.coeff : active_coeff;
      end
    end
  end

endmodule

//--- logic/complex_mult.sv
`timescale 1ns/1ps

module complex_mult
  import gain_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    stb_in,
  input  sample_t sample,
  input  coeff_t  coeff,
  output sample_t product,
  output logic    stb_out
);
  part_t              s_re;
  part_t              s_im;
  part_t              c_re;
  part_t              c_im;
  logic signed [31:0] p_rr;
  logic signed [31:0] p_ii;
  logic signed [31:0] p_ri;
  logic signed [31:0] p_ir;
  logic signed [32:0] sum_re;
  logic signed [32:0] sum_im;
  logic [2:0]         stb_pipe;

  // Drop the fraction bits, then clamp to the part range
  function automatic part_t saturate(input logic signed [32:0] value);
    logic signed [32:0] shifted;
    shifted = value >>> COEFF_FRAC_BITS;
    if (shifted > PART_MAX) begin
      return PART_MAX;
    end else if (shifted < PART_MIN) begin
      return PART_MIN;
    end
    return shifted[15:0];
  endfunction

  // Real part in the upper half
  assign s_re = sample[31:16];
  assign s_im = sample[15:0];
  assign c_re = coeff[31:16];
  assign c_im = coeff[15:0];

  // ------------------------------
  // Three stage data pipeline
  // ------------------------------
  always_ff @(posedge clk) begin
    // Stage one, partial products
    p_rr <= s_re * c_re;
    p_ii <= s_im * c_im;
    p_ri <= s_re * c_im;
    p_ir <= s_im * c_re;
    // Stage two, one extra bit covers the sum
    sum_re <= p_rr - p_ii;
    sum_im <= p_ri + p_ir;
    // Stage three, scale and saturate
    product <= {saturate(sum_re), saturate(sum_im)};
  end

  // Strobe follows the data stages
  always_ff @(posedge clk) begin
    if (rst) begin
      stb_pipe <= '0;
    end else begin
      stb_pipe <= {stb_pipe[1:0], stb_in};
    end
  end

  assign stb_out = stb_pipe[2];

endmodule

//--- logic/timed_complex_gain.sv
`timescale 1ns/1ps

module timed_complex_gain
  import ctrl_port_pkg::*;
  import gain_pkg::*;
#(
  parameter int NIPC        = 2,
  parameter int QUEUE_DEPTH = 4,
  parameter int BASE_ADDR   = 0
) (
  input  logic               clk,
  input  logic               rst,
  input  ctrl_req_t          ctrl_req,
  output ctrl_resp_t         ctrl_resp,
  input  sample_t [NIPC-1:0] data_in,
  input  logic               data_in_stb,
  input  timestamp_t         timestamp,
  output sample_t [NIPC-1:0] data_out,
  output logic               data_out_stb
);
  // Register block to queue
  logic               push;
  gain_cmd_t          push_cmd;
  logic               queue_full;
  // Queue to scheduler
  logic               pop;
  gain_cmd_t          head_cmd;
  logic               queue_not_empty;
  // Scheduler outputs
  coeff_t             active_coeff;
  coeff_t  [NIPC-1:0] item_coeff;
  sample_t [NIPC-1:0] item_data;
  logic               item_stb;
  logic    [NIPC-1:0] mult_stb;

  // ------------------------------
  // Control path
  // ------------------------------
  gain_ctrl_regs #(
    .BASE_ADDR (BASE_ADDR)
  ) ctrl_regs_inst (
    .clk          (clk),
    .rst          (rst),
    .ctrl_req     (ctrl_req),
    .ctrl_resp    (ctrl_resp),
    .active_coeff (active_coeff),
    .push         (push),
    .push_cmd     (push_cmd),
    .full         (queue_full)
  );

  coeff_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) queue_inst (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .push_cmd  (push_cmd),
    .full      (queue_full),
    .pop       (pop),
    .head_cmd  (head_cmd),
    .not_empty (queue_not_empty)
  );

  gain_scheduler #(
    .NIPC (NIPC)
  ) scheduler_inst (
    .clk          (clk),
    .rst          (rst),
    .data_in_stb  (data_in_stb),
    .data_in      (data_in),
    .timestamp    (timestamp),
    .head_cmd     (head_cmd),
    .not_empty    (queue_not_empty),
    .pop          (pop),
    .active_coeff (active_coeff),
    .item_coeff   (item_coeff),
    .item_data    (item_data),
    .item_stb     (item_stb)
  );

  // ------------------------------
  // One multiplier per item
  // ------------------------------
  for (genvar i = 0; i < NIPC; i++) begin : gen_mult
    complex_mult mult_inst (
      .clk     (clk),
      .rst     (rst),
      .stb_in  (item_stb),
      .sample  (item_data[i]),
      .coeff   (item_coeff[i]),
      .product (data_out[i]),
      .stb_out (mult_stb[i])
    );
  end

  // All lanes run in lockstep
  assign data_out_stb = &mult_stb;

endmodule

//--- verification/timed_complex_gain_sva.sv
`timescale 1ns/1ps

module timed_complex_gain_sva
  import ctrl_port_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input logic       data_in_stb,
  input logic       data_out_stb,
  input ctrl_resp_t ctrl_resp,
  input logic       push,
  input logic       full,
  input logic       pop,
  input logic       not_empty
);

  // ------------------------------
  // Data path strobes
  // ------------------------------
  // Output pipeline empty once reset is seen
  a_out_stb_reset: assert property (@(posedge clk) rst |=> !data_out_stb)
    else $error("data_out_stb high after reset");

  // Fixed latency of four cycles
  a_latency: assert property (@(posedge clk) disable iff (rst)
    data_in_stb |-> ##4 data_out_stb)
    else $error("data_out_stb missing four cycles after data_in_stb");

  a_no_extra_out: assert property (@(posedge clk) disable iff (rst)
    data_out_stb |-> $past(data_in_stb, 4))
    else $error("data_out_stb without a matching data_in_stb");

  // ------------------------------
  // Control and queue
  // ------------------------------
  a_ack_single: assert property (@(posedge clk) disable iff (rst)
    ctrl_resp.ack |=> !ctrl_resp.ack)
    else $error("Acknowledge longer than one cycle");

  // Full queue keeps its entries while an offered command waits
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    push && full && !pop |=> full)
    else $error("Queue accepted a push while full");

  // Empty queue stays empty unless a command is pushed
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    !not_empty && !push |=> !not_empty)
    else $error("Queue popped while empty");

endmodule

bind timed_complex_gain timed_complex_gain_sva sva_inst (
  .clk          (clk),
  .rst          (rst),
  .data_in_stb  (data_in_stb),
  .data_out_stb (data_out_stb),
  .ctrl_resp    (ctrl_resp),
  .push         (push),
  .full         (queue_full),
  .pop          (pop),
  .not_empty    (queue_not_empty)
);

//--- verification/timed_complex_gain_tb.sv
`timescale 1ns/1ps

module timed_complex_gain_tb
  import ctrl_port_pkg::*;
  import gain_pkg::*;
();
  localparam int NIPC        = 2;
  localparam int QUEUE_DEPTH = 4;
  // About 200 strobe and control cycles in all, limit leaves wide margin
  localparam int MAX_CYCLES  = 2000;
  // Coefficient register at word offset 0 of a block based at 0
  localparam ctrl_addr_t COEFF_ADDR    = 20'h0_0000;
  localparam ctrl_addr_t UNMAPPED_ADDR = 20'h0_0040;

  // Expected output of one strobe and the cycle it must appear in
  typedef struct packed {
    logic [31:0]        cycle;
    sample_t [NIPC-1:0] data;
  } expect_t;

  logic               clk;
  logic               rst;
  ctrl_req_t          ctrl_req;
  ctrl_resp_t         ctrl_resp;
  sample_t [NIPC-1:0] data_in;
  logic               data_in_stb;
  timestamp_t         timestamp;
  sample_t [NIPC-1:0] data_out;
  logic               data_out_stb;

  // Reference model state
  expect_t    exp_q [$];
  gain_cmd_t  model_q [$];
  coeff_t     model_active;
  timestamp_t next_ts;
  integer     seed;
  int         cycle;
  int         checks;
  int         errors;

  timed_complex_gain #(
    .NIPC        (NIPC),
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .BASE_ADDR   (0)
  ) timed_complex_gain_inst (
    .clk          (clk),
    .rst          (rst),
    .ctrl_req     (ctrl_req),
    .ctrl_resp    (ctrl_resp),
    .data_in      (data_in),
    .data_in_stb  (data_in_stb),
    .timestamp    (timestamp),
    .data_out     (data_out),
    .data_out_stb (data_out_stb)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Cycle count, also guards against a hang
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("Run stopped by timeout after %0d cycles", cycle);
      $display("Test FAILED");
      $finish;
    end
  end

  // ------------------------------
  // Reference model
  // ------------------------------
  // Clamp one part to signed 16 bits
  function automatic logic [15:0] clamp_part(input longint value);
    if (value > 32767) begin
      return 16'h7fff;
    end
    if (value < -32768) begin
      return 16'h8000;
    end
    return value[15:0];
  endfunction

  // Complex product, Q1.14 coefficient, arithmetic shift then clamp
  function automatic sample_t ref_product(input sample_t s, input coeff_t c);
    longint s_re;
    longint s_im;
    longint c_re;
    longint c_im;
    longint re;
    longint im;
    s_re = $signed(s[31:16]);
    s_im = $signed(s[15:0]);
    c_re = $signed(c[31:16]);
    c_im = $signed(c[15:0]);
    re = (s_re * c_re - s_im * c_im) >>> 14;
    im = (s_re * c_im + s_im * c_re) >>> 14;
    return {clamp_part(re), clamp_part(im)};
  endfunction

  // One strobe through the model queue, at most one entry applied
  function automatic void model_strobe(input timestamp_t ts,
                                       input sample_t [NIPC-1:0] d,
                                       output sample_t [NIPC-1:0] exp);
    gain_cmd_t head;
    logic      due;
    coeff_t    c;
    head = '0;
    due  = 1'b0;
    if (model_q.size() > 0) begin
      head = model_q[0];
      // Due once its time lies at or before the last item
      due  = !head.timed || (head.ts <= ts + NIPC - 1);
    end
    for (int i = 0; i < NIPC; i++) begin
      if (due && (!head.timed || ts + i >= head.ts)) begin
        c = head.coeff;
      end else begin
        c = model_active;
      end
      exp[i] = ref_product(d[i], c);
    end
    if (due) begin
      model_active = head.coeff;
      void'(model_q.pop_front());
    end
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_coeff(input string name, input coeff_t exp, input coeff_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_status(input string name, input ctrl_status_e exp,
                              input ctrl_status_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t %s expected %s actual %0d", $time, name, exp.name(), act);
    end
  endtask

  // Outputs sampled mid cycle, where they are stable
  always @(negedge clk) begin
    expect_t e;
    if (!rst && data_out_stb) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Output strobe at %0t with no input strobe pending", $time);
      end else begin
        e = exp_q.pop_front();
        if (cycle != e.cycle) begin
          errors++;
          $display("Output strobe in cycle %0d, due in cycle %0d", cycle, e.cycle);
        end
        for (int i = 0; i < NIPC; i++) begin
          check_sample($sformatf("data_out[%0d]", i), e.data[i], data_out[i]);
        end
      end
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  // Back to back strobes with random items
  task automatic drive_strobes(input int n);
    expect_t            e;
    sample_t [NIPC-1:0] d;
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      #0.5;
      for (int i = 0; i < NIPC; i++) begin
        d[i] = $random(seed);
      end
      data_in     = d;
      timestamp   = next_ts;
      data_in_stb = 1'b1;
      e.cycle     = cycle + 4;
      model_strobe(next_ts, d, e.data);
      exp_q.push_back(e);
      next_ts += NIPC;
    end
    @(posedge clk);
    #0.5;
    data_in_stb = 1'b0;
  endtask

  task automatic drain_outputs();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // One cycle control request
  task automatic send_req(input logic wr, input logic rd, input ctrl_addr_t addr,
                          input ctrl_data_t data, input logic has_time,
                          input timestamp_t t);
    @(posedge clk);
    #0.5;
    ctrl_req.wr       = wr;
    ctrl_req.rd       = rd;
    ctrl_req.addr     = addr;
    ctrl_req.data     = data;
    ctrl_req.has_time = has_time;
    ctrl_req.req_time = t;
    @(posedge clk);
    #0.5;
    ctrl_req = '0;
  endtask

  task automatic wait_ack(input int limit, output logic seen, output ctrl_resp_t resp);
    seen = 1'b0;
    resp = '0;
    for (int k = 0; k < limit && !seen; k++) begin
      @(negedge clk);
      if (ctrl_resp.ack) begin
        seen = 1'b1;
        resp = ctrl_resp;
      end
    end
  endtask

  // Model queue follows request order
  task automatic issue_write(input coeff_t c, input logic timed, input timestamp_t t);
    gain_cmd_t cmd;
    cmd.coeff = c;
    cmd.timed = timed;
    cmd.ts    = timed ? t : '0;
    model_q.push_back(cmd);
    send_req(1'b1, 1'b0, COEFF_ADDR, c, timed, t);
  endtask

  task automatic expect_write_ack(input int limit);
    logic       seen;
    ctrl_resp_t resp;
    wait_ack(limit, seen, resp);
    if (!seen) begin
      errors++;
      $display("Coefficient write got no acknowledge within %0d cycles", limit);
    end else begin
      check_status("ctrl_resp.status", CTRL_STS_OKAY, resp.status);
    end
  endtask

  task automatic write_coeff(input coeff_t c, input logic timed, input timestamp_t t);
    issue_write(c, timed, t);
    expect_write_ack(5);
  endtask

  task automatic read_coeff(input logic timed, input coeff_t exp_coeff,
                            input ctrl_status_e exp_status);
    logic       seen;
    ctrl_resp_t resp;
    send_req(1'b0, 1'b1, COEFF_ADDR, '0, timed, timed ? next_ts : '0);
    wait_ack(3, seen, resp);
    if (!seen) begin
      errors++;
      $display("Coefficient read got no acknowledge");
    end else begin
      check_status("ctrl_resp.status", exp_status, resp.status);
      check_coeff("ctrl_resp.data", exp_coeff, resp.data);
    end
  endtask

  task automatic report_test(input string title, input int start_errors);
    drain_outputs();
    $display("%s: done, %0d errors", title, errors - start_errors);
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    coeff_t     gains [4];
    coeff_t     queued [4];
    timestamp_t base;
    int         start_errors;
    logic       seen;
    ctrl_resp_t resp;
    seed         = 32'hf84b_97bd;
    cycle        = 0;
    checks       = 0;
    errors       = 0;
    rst          = 1'b1;
    ctrl_req     = '0;
    data_in      = '0;
    data_in_stb  = 1'b0;
    timestamp    = '0;
    model_active = COEFF_UNITY;
    next_ts      = '0;
    repeat (8) @(posedge clk);
    #0.5;
    rst = 1'b0;

    // Unity coefficient after reset
    start_errors = errors;
    read_coeff(1'b0, COEFF_UNITY, CTRL_STS_OKAY);
    drive_strobes(8);
    report_test("reset state", start_errors);

    // Untimed writes, negative and saturating parts included
    start_errors = errors;
    gains = '{32'h2000_c000, 32'hd000_1800, 32'h7fff_7fff, 32'h8000_8000};
    for (int g = 0; g < 4; g++) begin
      write_coeff(gains[g], 1'b0, '0);
      drive_strobes(6);
      drain_outputs();
      read_coeff(1'b0, gains[g], CTRL_STS_OKAY);
    end
    report_test("untimed writes", start_errors);

    // Timed write on item 1 of the fourth strobe
    start_errors = errors;
    base = next_ts;
    write_coeff(32'h3000_e000, 1'b1, base + 7);
    drive_strobes(6);
    report_test("timed write on item 1", start_errors);

    // Fill the queue, fifth write is held off
    start_errors = errors;
    base   = next_ts;
    queued = '{32'h1000_0000, 32'h0000_4000, 32'hc000_2000, 32'h3000_d000};
    write_coeff(queued[0], 1'b1, base + 4);
    write_coeff(queued[1], 1'b1, base + 7);
    write_coeff(queued[2], 1'b1, base + 10);
    write_coeff(queued[3], 1'b1, base + 15);
    issue_write(COEFF_UNITY, 1'b1, base + 20);
    wait_ack(10, seen, resp);
    if (seen) begin
      errors++;
      $display("Write acknowledged while the command queue was full");
    end
    fork
      expect_write_ack(60);
      drive_strobes(14);
    join
    drain_outputs();
    read_coeff(1'b0, COEFF_UNITY, CTRL_STS_OKAY);
    report_test("queue full", start_errors);

    // Timed read and unmapped addresses
    start_errors = errors;
    read_coeff(1'b1, '0, CTRL_STS_CMD_ERR);
    send_req(1'b0, 1'b1, UNMAPPED_ADDR, '0, 1'b0, '0);
    wait_ack(10, seen, resp);
    if (seen) begin
      errors++;
      $display("Read of an unmapped address was acknowledged");
    end
    send_req(1'b1, 1'b0, UNMAPPED_ADDR, 32'h1234_5678, 1'b0, '0);
    wait_ack(10, seen, resp);
    if (seen) begin
      errors++;
      $display("Write to an unmapped address was acknowledged");
    end
    report_test("timed read and unmapped address", start_errors);

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+logic
logic/gain_pkg.sv
logic/ctrl_port_pkg.sv
logic/gain_ctrl_regs.sv
logic/coeff_queue.sv
logic/gain_scheduler.sv
logic/complex_mult.sv
logic/timed_complex_gain.sv
verification/timed_complex_gain_sva.sv
verification/timed_complex_gain_tb.sv

//--- Bender.yml
package:
  name: timed_complex_gain

sources:
  - include_dirs:
      - logic
    files:
      - logic/gain_pkg.sv
      - logic/ctrl_port_pkg.sv
      - logic/gain_ctrl_regs.sv
      - logic/coeff_queue.sv
      - logic/gain_scheduler.sv
      - logic/complex_mult.sv
      - logic/timed_complex_gain.sv
  - target: test
    files:
      - verification/timed_complex_gain_sva.sv
      - verification/timed_complex_gain_tb.sv
